// ==== common/vram_blit_pkg.sv ====
// shared types and register map for the tile video host interface, imported by every rtl block
`default_nettype none

package vram_blit_pkg;

    // one vram or host register word
    typedef logic [15:0] word_t;

    // host register numbers on the byte bus
    typedef enum logic [3:0] {
        XM_STATUS     = 4'd0,   // ro, bit 15 = blit busy
        XM_INT_CTRL   = 4'd1,   // mask in bit 8, pending in bit 0
        XM_WR_ADDR    = 4'd2,   // vram write address
        XM_DATA       = 4'd3,   // vram data port, both directions
        XM_RD_ADDR    = 4'd4,   // vram read address
        XM_BLIT_DST   = 4'd5,   // fill destination
        XM_BLIT_VALUE = 4'd6,   // fill word
        XM_BLIT_COUNT = 4'd7    // words minus one, write starts blit
    } reg_num_e;

    // blitter sequencing
    typedef enum logic [1:0] {
        BLIT_IDLE = 2'd0,
        BLIT_RUN  = 2'd1,
        BLIT_DONE = 2'd2
    } blit_state_e;

    // interrupt bit positions
    // pending status at this bit of XM_INT_CTRL, mask at 8 above it
    localparam int INTR_BLIT = 0;

endpackage

`default_nettype wire

// ==== regs/reg_interface.sv ====
// host byte bus registers, drives the host vram client, starts blits and keeps blit interrupt state
`default_nettype none
`timescale 1ns/10ps

module reg_interface
    import vram_blit_pkg::*;
#(
    parameter int VRAM_AW = 12
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               bus_cs_n_i,
    input  wire logic               bus_rd_nwr_i,
    input  wire logic [3:0]         bus_reg_num_i,
    input  wire logic               bus_bytesel_i,
    input  wire logic [7:0]         bus_data_i,
    output logic      [7:0]         bus_data_o,     // registered, held until next read
    output logic                    bus_intr_o,
    output logic                    regs_sel_o,     // held until ack
    output logic                    regs_wr_o,
    output logic      [VRAM_AW-1:0] regs_addr_o,
    output word_t                   regs_wdata_o,
    input  wire logic               regs_ack_i,
    input  wire word_t              vram_rdata_i,   // valid with ack
    output logic                    blit_start_o,   // one cycle pulse
    output logic      [VRAM_AW-1:0] blit_dst_o,
    output logic      [VRAM_AW-1:0] blit_count_o,
    output word_t                   blit_value_o,
    input  wire logic               blit_busy_i,
    input  wire logic               blit_done_i     // one cycle pulse
);

reg_num_e           reg_num;
logic               cs_wr;          // write strobe, either byte
logic               cs_rd;          // read strobe, either byte
logic               word_wr;        // odd byte write completes a word
logic               data_rd;        // odd byte read of XM_DATA, fetches next word
logic               intr_clear;     // host clears blit pending
logic [7:0]         hi_byte_q;      // even byte, latched only
word_t              wr_word;
word_t              rd_word;        // word selected for readback
word_t              rd_data_q;      // prefetched vram word
logic [VRAM_AW-1:0] wr_addr_q;
logic [VRAM_AW-1:0] rd_addr_q;      // next prefetch address
logic               intr_mask_q;
logic               intr_pend_q;

assign reg_num    = reg_num_e'(bus_reg_num_i);
assign cs_wr      = ~bus_cs_n_i & ~bus_rd_nwr_i;
assign cs_rd      = ~bus_cs_n_i & bus_rd_nwr_i;
assign word_wr    = cs_wr & bus_bytesel_i;
assign data_rd    = cs_rd & bus_bytesel_i && (reg_num == XM_DATA);
assign wr_word    = {hi_byte_q, bus_data_i};    // even byte is the high byte
assign intr_clear = word_wr && (reg_num == XM_INT_CTRL) && wr_word[INTR_BLIT];

// readback mux, unlisted numbers read zero
always_comb begin
    rd_word = '0;
    case (reg_num)
        XM_STATUS:      rd_word[15] = blit_busy_i;
        XM_INT_CTRL: begin
            rd_word[8 + INTR_BLIT] = intr_mask_q;
            rd_word[INTR_BLIT]     = intr_pend_q;
        end
        XM_WR_ADDR:     rd_word = word_t'(wr_addr_q);
        XM_DATA:        rd_word = rd_data_q;
        XM_RD_ADDR:     rd_word = word_t'(rd_addr_q);
        XM_BLIT_DST:    rd_word = word_t'(blit_dst_o);
        XM_BLIT_VALUE:  rd_word = blit_value_o;
        XM_BLIT_COUNT:  rd_word = word_t'(blit_count_o);
        default:        rd_word = '0;
    endcase
end

// control state
always_ff @(posedge clk) begin
    if (reset_i) begin
        bus_data_o   <= '0;
        bus_intr_o   <= 1'b0;
        regs_sel_o   <= 1'b0;
        regs_wr_o    <= 1'b0;
        wr_addr_q    <= '0;
        rd_addr_q    <= '0;
        blit_start_o <= 1'b0;
        intr_mask_q  <= 1'b0;
        intr_pend_q  <= 1'b0;
    end else begin
        blit_start_o <= 1'b0;
        if (regs_ack_i) begin
            regs_sel_o <= 1'b0;     // vram access done
        end
        if (cs_rd) begin
            bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
        end
        if (data_rd) begin          // prefetch next word
            regs_sel_o <= 1'b1;
            regs_wr_o  <= 1'b0;
            rd_addr_q  <= rd_addr_q + 1'b1;
        end
        if (word_wr) begin
            case (reg_num)
                XM_INT_CTRL:    intr_mask_q <= wr_word[8 + INTR_BLIT];
                XM_WR_ADDR:     wr_addr_q   <= wr_word[VRAM_AW-1:0];
                XM_DATA: begin
                    regs_sel_o <= 1'b1;
                    regs_wr_o  <= 1'b1;
                    wr_addr_q  <= wr_addr_q + 1'b1;     // auto increment
                end
                XM_RD_ADDR: begin   // new address, prefetch at once
                    regs_sel_o <= 1'b1;
                    regs_wr_o  <= 1'b0;
                    rd_addr_q  <= wr_word[VRAM_AW-1:0] + 1'b1;
                end
                XM_BLIT_COUNT:  blit_start_o <= ~blit_busy_i;   // dropped while busy
                default: ;
            endcase
        end
        // interrupt only on a fresh pending edge
        bus_intr_o  <= blit_done_i & intr_mask_q & ~intr_pend_q;
        intr_pend_q <= (intr_pend_q & ~intr_clear) | blit_done_i;
    end
end

// payload registers
always_ff @(posedge clk) begin
    if (cs_wr & ~bus_bytesel_i) begin
        hi_byte_q <= bus_data_i;
    end
    if (regs_ack_i & ~regs_wr_o) begin
        rd_data_q <= vram_rdata_i;  // prefetch lands here
    end
    if (data_rd) begin
        regs_addr_o <= rd_addr_q;
    end
    if (word_wr) begin
        case (reg_num)
            XM_DATA: begin
                regs_addr_o  <= wr_addr_q;
                regs_wdata_o <= wr_word;
            end
            XM_RD_ADDR:     regs_addr_o <= wr_word[VRAM_AW-1:0];
            // blit parameters locked while a fill runs
            XM_BLIT_DST:    if (!blit_busy_i) blit_dst_o <= wr_word[VRAM_AW-1:0];
            XM_BLIT_VALUE:  if (!blit_busy_i) blit_value_o <= wr_word;
            XM_BLIT_COUNT:  if (!blit_busy_i) blit_count_o <= wr_word[VRAM_AW-1:0];
            default: ;
        endcase
    end
end

endmodule

`default_nettype wire

// ==== blit/blit_fsm.sv ====
// fill blit sequencer, holds the vram select during a run and flags busy and done
`default_nettype none
`timescale 1ns/10ps

module blit_fsm
    import vram_blit_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire logic   blit_start_i,   // start pulse from registers
    input  wire logic   blit_last_i,    // current word is the final one
    input  wire logic   blit_ack_i,     // vram wrote one word
    output logic        blit_sel_o,
    output logic        blit_busy_o,
    output logic        blit_done_o,    // one cycle
    output logic        blit_step_o     // advance counter
);

blit_state_e state_q;
blit_state_e state_d;

always_comb begin
    state_d = state_q;
    case (state_q)
        BLIT_IDLE: begin
            if (blit_start_i) begin
                state_d = BLIT_RUN;
            end
        end
        BLIT_RUN: begin
            if (blit_ack_i && blit_last_i) begin
                state_d = BLIT_DONE;    // final word written
            end
        end
        BLIT_DONE:  state_d = BLIT_IDLE;
        default:    state_d = BLIT_IDLE;
    endcase
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        state_q <= BLIT_IDLE;
    end else begin
        state_q <= state_d;
    end
end

// select drops in the final ack cycle so no word past the range is written
assign blit_sel_o  = (state_q == BLIT_RUN) && !(blit_ack_i && blit_last_i);
assign blit_step_o = (state_q == BLIT_RUN) && blit_ack_i;
assign blit_busy_o = (state_q != BLIT_IDLE);    // through the done cycle
assign blit_done_o = (state_q == BLIT_DONE);

endmodule

`default_nettype wire

// ==== blit/blit_counter.sv ====
// fill blit address and remaining word counter, advanced once per acked vram write
`default_nettype none
`timescale 1ns/10ps

module blit_counter #(
    parameter int VRAM_AW = 12
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               load_i,     // blit start
    input  wire logic [VRAM_AW-1:0] dst_i,
    input  wire logic [VRAM_AW-1:0] count_i,    // words minus one
    input  wire logic               step_i,     // one word done
    output logic      [VRAM_AW-1:0] addr_o,
    output logic                    last_o
);

logic [VRAM_AW-1:0] addr_q;
logic [VRAM_AW-1:0] rem_q;      // words left after the current one

always_ff @(posedge clk) begin
    if (reset_i) begin
        addr_q <= '0;
        rem_q  <= '0;
    end else if (load_i) begin
        addr_q <= dst_i;
        rem_q  <= count_i;
    end else if (step_i) begin
        addr_q <= addr_q + 1'b1;
        rem_q  <= rem_q - 1'b1;
    end
end

// look ahead one word on a step, the arbiter can write every cycle
assign addr_o = addr_q + {{(VRAM_AW-1){1'b0}}, step_i};
assign last_o = (rem_q == '0);

endmodule

`default_nettype wire

// ==== vram/vram_arb.sv ====
// video memory with a two client arbiter, host first and fill blitter when the host is quiet
`default_nettype none
`timescale 1ns/10ps

module vram_arb
    import vram_blit_pkg::*;
#(
    parameter int VRAM_AW = 12
) (
    input  wire logic               clk,
    input  wire logic               regs_sel_i,
    input  wire logic               regs_wr_i,
    input  wire logic [VRAM_AW-1:0] regs_addr_i,
    input  wire word_t              regs_wdata_i,
    output logic                    regs_ack_o,
    input  wire logic               blit_sel_i,
    input  wire logic [VRAM_AW-1:0] blit_addr_i,
    input  wire word_t              blit_wdata_i,   // blitter only writes
    output logic                    blit_ack_o,
    output word_t                   rdata_o         // host read data, valid with ack
);

word_t  vram_mem [2**VRAM_AW];
logic   regs_go;    // host served this clock
logic   blit_go;    // blitter served this clock

// host select stays up through its ack cycle, so skip it there
assign regs_go = regs_sel_i & ~regs_ack_o;
// any host select blocks the blitter, which stalls
assign blit_go = blit_sel_i & ~regs_sel_i;

always_ff @(posedge clk) begin
    regs_ack_o <= regs_go;
    blit_ack_o <= blit_go;      // marks a write done while host was idle
    if (regs_go) begin
        if (regs_wr_i) begin
            vram_mem[regs_addr_i] <= regs_wdata_i;
        end else begin
            rdata_o <= vram_mem[regs_addr_i];
        end
    end else if (blit_go) begin
        vram_mem[blit_addr_i] <= blit_wdata_i;
    end
end

endmodule

`default_nettype wire

// ==== src/vram_blit_top.sv ====
// top level of the host side video controller, connects byte bus registers, fill blitter and vram
`default_nettype none
`timescale 1ns/10ps

module vram_blit_top
    import vram_blit_pkg::*;
#(
    parameter int VRAM_AW = 12              // vram address width
) (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           bus_cs_n_i,     // one clock strobe, active low
    input  wire logic           bus_rd_nwr_i,   // 1 = read, 0 = write
    input  wire logic [3:0]     bus_reg_num_i,  // register number
    input  wire logic           bus_bytesel_i,  // 0 = even/high byte, 1 = odd/low byte
    input  wire logic [7:0]     bus_data_i,
    output logic      [7:0]     bus_data_o,
    output logic                bus_intr_o      // blit done interrupt pulse
);

// host vram client
logic                   regs_sel;
logic                   regs_wr;
logic [VRAM_AW-1:0]     regs_addr;
word_t                  regs_wdata;
logic                   regs_ack;
word_t                  vram_rdata;

// blit control from registers
logic                   blit_start;
logic [VRAM_AW-1:0]     blit_dst;
logic [VRAM_AW-1:0]     blit_count;
word_t                  blit_value;
logic                   blit_busy;
logic                   blit_done;

// blit vram client
logic                   blit_sel;
logic                   blit_ack;
logic                   blit_step;
logic                   blit_last;
logic [VRAM_AW-1:0]     blit_addr;

reg_interface #(
    .VRAM_AW(VRAM_AW)
) reg_interface_i (
    .clk(clk),
    .reset_i(reset_i),
    .bus_cs_n_i(bus_cs_n_i),
    .bus_rd_nwr_i(bus_rd_nwr_i),
    .bus_reg_num_i(bus_reg_num_i),
    .bus_bytesel_i(bus_bytesel_i),
    .bus_data_i(bus_data_i),
    .bus_data_o(bus_data_o),
    .bus_intr_o(bus_intr_o),
    .regs_sel_o(regs_sel),
    .regs_wr_o(regs_wr),
    .regs_addr_o(regs_addr),
    .regs_wdata_o(regs_wdata),
    .regs_ack_i(regs_ack),
    .vram_rdata_i(vram_rdata),
    .blit_start_o(blit_start),
    .blit_dst_o(blit_dst),
    .blit_count_o(blit_count),
    .blit_value_o(blit_value),
    .blit_busy_i(blit_busy),
    .blit_done_i(blit_done)
);

blit_fsm blit_fsm_i (
    .clk(clk),
    .reset_i(reset_i),
    .blit_start_i(blit_start),
    .blit_last_i(blit_last),
    .blit_ack_i(blit_ack),
    .blit_sel_o(blit_sel),
    .blit_busy_o(blit_busy),
    .blit_done_o(blit_done),
    .blit_step_o(blit_step)
);

blit_counter #(
    .VRAM_AW(VRAM_AW)
) blit_counter_i (
    .clk(clk),
    .reset_i(reset_i),
    .load_i(blit_start),        // start pulse loads dst and count
    .dst_i(blit_dst),
    .count_i(blit_count),
    .step_i(blit_step),
    .addr_o(blit_addr),
    .last_o(blit_last)
);

vram_arb #(
    .VRAM_AW(VRAM_AW)
) vram_arb_i (
    .clk(clk),
    .regs_sel_i(regs_sel),
    .regs_wr_i(regs_wr),
    .regs_addr_i(regs_addr),
    .regs_wdata_i(regs_wdata),
    .regs_ack_o(regs_ack),
    .blit_sel_i(blit_sel),
    .blit_addr_i(blit_addr),
    .blit_wdata_i(blit_value),  // fill word straight from the register
    .blit_ack_o(blit_ack),
    .rdata_o(vram_rdata)
);

endmodule

`default_nettype wire

// ==== test/vram_blit_properties.sv ====
// concurrent checks on the vram client handshakes and the blit interrupt, bound into the rtl blocks
`default_nettype none
`timescale 1ns/10ps

module vram_blit_properties (
    input wire logic clk,
    input wire logic reset_i,
    input wire logic regs_sel_i,
    input wire logic regs_ack_i,
    input wire logic blit_sel_i,
    input wire logic blit_ack_i,
    input wire logic intr_i
);

// host has priority, ack lands one cycle after select
regs_ack_in_one: assert property (@(posedge clk) disable iff (reset_i)
    $rose(regs_sel_i) |=> regs_ack_i)
    else $error("regs_ack did not follow regs_sel by one cycle");

// blitter write never granted while the host holds vram
blit_yields: assert property (@(posedge clk) disable iff (reset_i)
    (blit_sel_i && regs_sel_i) |=> !blit_ack_i)
    else $error("blit_ack granted while regs_sel was high");

regs_sel_held: assert property (@(posedge clk) disable iff (reset_i)
    (regs_sel_i && !regs_ack_i) |=> (regs_sel_i || regs_ack_i))
    else $error("regs_sel dropped before its ack");

// blit select may fall in its final ack cycle
blit_sel_held: assert property (@(posedge clk) disable iff (reset_i)
    (blit_sel_i && !blit_ack_i) |=> (blit_sel_i || blit_ack_i))
    else $error("blit_sel dropped before its ack");

intr_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
    intr_i |=> !intr_i)
    else $error("bus_intr_o high for more than one cycle");

endmodule

// arbiter side, no reset there
bind vram_arb vram_blit_properties arb_props_i (
    .clk(clk),
    .reset_i(1'b0),
    .regs_sel_i(regs_sel_i),
    .regs_ack_i(regs_ack_o),
    .blit_sel_i(blit_sel_i),
    .blit_ack_i(blit_ack_o),
    .intr_i(1'b0)
);

bind reg_interface vram_blit_properties regs_props_i (
    .clk(clk),
    .reset_i(reset_i),
    .regs_sel_i(regs_sel_o),
    .regs_ack_i(regs_ack_i),
    .blit_sel_i(1'b0),
    .blit_ack_i(1'b0),
    .intr_i(bus_intr_o)
);

`default_nettype wire

// ==== test/vram_blit_tb.sv ====
// testbench for the video host interface, runs a stimulus table over the byte bus against a vram model
`default_nettype none
`timescale 1ns/10ps

module vram_blit_tb
    import vram_blit_pkg::*;
();

localparam int VRAM_AW    = 12;
localparam int FILL_WORDS = 192;    // background words written in test 1
localparam int WAIT_LIMIT = 100;    // status polls before giving up
localparam int OP_WR      = 0;      // full word write
localparam int OP_WR_HI   = 1;      // even byte only
localparam int OP_WR_LO   = 2;      // odd byte only
localparam int OP_RD      = 3;      // word read, compared with exp
localparam int OP_WAIT    = 4;      // poll status until blit idle
localparam int OP_INTR    = 5;      // interrupt pulses since last check
localparam int OP_END     = 6;      // data holds the test number

typedef struct {
    int         op;
    logic [3:0] num;
    word_t      data;
    word_t      exp;
} row_t;

logic       clk;
logic       reset;
logic       bus_cs_n;
logic       bus_rd_nwr;
logic [3:0] bus_reg_num;
logic       bus_bytesel;
logic [7:0] bus_wdata;
logic [7:0] bus_rdata;
logic       bus_intr;

word_t  vram_model [2**VRAM_AW];
row_t   stim_q [$];
integer seed = 58158;
int     errors = 0;
int     checks = 0;
int     test_errors = 0;
int     test_checks = 0;
int     tests_run = 0;
int     intr_count = 0;
int     intr_base = 0;

vram_blit_top #(
    .VRAM_AW(VRAM_AW)
) dut_i (
    .clk(clk),
    .reset_i(reset),
    .bus_cs_n_i(bus_cs_n),
    .bus_rd_nwr_i(bus_rd_nwr),
    .bus_reg_num_i(bus_reg_num),
    .bus_bytesel_i(bus_bytesel),
    .bus_data_i(bus_wdata),
    .bus_data_o(bus_rdata),
    .bus_intr_o(bus_intr)
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

always @(posedge clk) begin
    if (bus_intr === 1'b1) intr_count <= intr_count + 1;   // pulses seen so far
end

function automatic word_t rand_word();
    return word_t'($random(seed));
endfunction

task automatic add_row(input int op, input logic [3:0] num, input word_t data, input word_t exp);
    row_t r;
    r.op   = op;
    r.num  = num;
    r.data = data;
    r.exp  = exp;
    stim_q.push_back(r);
endtask

task automatic queue_write(input logic [3:0] num, input word_t data);
    add_row(OP_WR, num, data, '0);
endtask

// point the read address at first, then read n words back
task automatic verify_range(input int first, input int n);
    queue_write(XM_RD_ADDR, word_t'(first));
    for (int i = 0; i < n; i++) begin
        add_row(OP_RD, XM_DATA, '0, vram_model[first + i]);
    end
endtask

task automatic queue_fill(input int dst, input int count, input word_t value);
    queue_write(XM_BLIT_DST, word_t'(dst));
    queue_write(XM_BLIT_VALUE, value);
    queue_write(XM_BLIT_COUNT, word_t'(count));     // starts the fill
    for (int i = 0; i <= count; i++) begin
        vram_model[dst + i] = value;
    end
endtask

// one strobe plus 4 idle cycles, inputs change on the falling edge
task automatic bus_strobe(input logic rd, input logic [3:0] num, input logic bsel,
                          input logic [7:0] din);
    @(negedge clk);
    bus_cs_n    = 1'b0;
    bus_rd_nwr  = rd;
    bus_reg_num = num;
    bus_bytesel = bsel;
    bus_wdata   = din;
    @(negedge clk);
    bus_cs_n = 1'b1;
    repeat (3) @(negedge clk);
endtask

task automatic write_word(input logic [3:0] num, input word_t data);
    bus_strobe(1'b0, num, 1'b0, data[15:8]);    // high byte first, only latched
    bus_strobe(1'b0, num, 1'b1, data[7:0]);
endtask

task automatic read_word(input logic [3:0] num, output word_t data);
    bus_strobe(1'b1, num, 1'b0, 8'h00);
    data[15:8] = bus_rdata;
    bus_strobe(1'b1, num, 1'b1, 8'h00);
    data[7:0] = bus_rdata;
endtask

task automatic check_value(input string name, input word_t got, input word_t exp);
    test_checks++;
    if (got !== exp) begin
        $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        test_errors++;
    end
endtask

task automatic wait_idle();
    word_t status;
    int    polls;
    status = 16'h8000;
    polls  = 0;
    while (status[15] && polls < WAIT_LIMIT) begin
        read_word(XM_STATUS, status);
        polls++;
    end
    if (status[15]) begin
        $display("timeout at %0t ns: blit busy flag never cleared", $time);
        test_errors++;
    end
endtask

task automatic apply_row(input row_t r);
    word_t got;
    case (r.op)
        OP_WR:    write_word(r.num, r.data);
        OP_WR_HI: bus_strobe(1'b0, r.num, 1'b0, r.data[15:8]);
        OP_WR_LO: bus_strobe(1'b0, r.num, 1'b1, r.data[7:0]);
        OP_RD: begin
            read_word(r.num, got);
            check_value($sformatf("bus_data_o reg %0d", r.num), got, r.exp);
        end
        OP_WAIT:  wait_idle();
        OP_INTR: begin
            check_value("bus_intr_o pulses", word_t'(intr_count - intr_base), r.exp);
            intr_base = intr_count;
        end
        default: begin      // end of a test
            $display("test %0d: %0d checks, %0d errors", r.data, test_checks, test_errors);
            errors += test_errors;
            checks += test_checks;
            test_errors = 0;
            test_checks = 0;
            tests_run++;
        end
    endcase
endtask

task automatic build_table();
    word_t w;
    // 1 write then read back a block, both addresses auto increment
    queue_write(XM_WR_ADDR, '0);
    for (int i = 0; i < FILL_WORDS; i++) begin
        vram_model[i] = rand_word();
        queue_write(XM_DATA, vram_model[i]);
    end
    verify_range(0, FILL_WORDS);
    add_row(OP_END, '0, 16'd1, '0);
    // 2 even byte alone is latched, odd byte completes the word
    w = rand_word();
    queue_write(XM_WR_ADDR, 16'h0040);
    queue_write(XM_RD_ADDR, 16'h003F);
    add_row(OP_WR_HI, XM_DATA, w, '0);
    add_row(OP_RD, XM_DATA, '0, vram_model[16'h03F]);
    add_row(OP_RD, XM_DATA, '0, vram_model[16'h040]);  // fetched after the even byte
    add_row(OP_WR_LO, XM_DATA, w, '0);
    vram_model[16'h040] = w;
    verify_range(16'h03F, 3);
    add_row(OP_END, '0, 16'd2, '0);
    // 3 plain fill, neighbours untouched
    queue_fill(16'h010, 31, rand_word());
    add_row(OP_RD, XM_STATUS, '0, 16'h8000);
    add_row(OP_WAIT, '0, '0, '0);
    verify_range(16'h00F, 34);
    add_row(OP_END, '0, 16'd3, '0);
    // 4 host writes land while the blitter stalls
    queue_fill(16'h060, 63, rand_word());
    queue_write(XM_WR_ADDR, 16'h00A8);
    for (int i = 0; i < 6; i++) begin
        vram_model[16'h0A8 + i] = rand_word();
        queue_write(XM_DATA, vram_model[16'h0A8 + i]);
    end
    add_row(OP_WAIT, '0, '0, '0);
    verify_range(16'h05F, 66);
    verify_range(16'h0A7, 8);
    add_row(OP_END, '0, 16'd4, '0);
    // 5 masked and unmasked done interrupt
    add_row(OP_INTR, '0, '0, '0);                   // earlier fills ran unmasked
    queue_write(XM_INT_CTRL, 16'h0101);             // mask on, old pending cleared
    queue_fill(16'h0B0, 3, rand_word());
    add_row(OP_WAIT, '0, '0, '0);
    add_row(OP_INTR, '0, '0, 16'd1);
    add_row(OP_RD, XM_INT_CTRL, '0, 16'h0101);
    queue_write(XM_INT_CTRL, 16'h0101);
    add_row(OP_RD, XM_INT_CTRL, '0, 16'h0100);
    queue_write(XM_INT_CTRL, 16'h0000);             // mask off
    queue_fill(16'h0B0, 3, rand_word());
    add_row(OP_WAIT, '0, '0, '0);
    add_row(OP_INTR, '0, '0, '0);
    add_row(OP_RD, XM_INT_CTRL, '0, 16'h0001);      // pending still set
    add_row(OP_END, '0, 16'd5, '0);
    // 6 second count write while busy is dropped
    queue_fill(16'h020, 31, rand_word());
    queue_write(XM_BLIT_COUNT, 16'd95);
    add_row(OP_WAIT, '0, '0, '0);
    add_row(OP_RD, XM_BLIT_COUNT, '0, 16'd31);
    verify_range(16'h01F, 65);
    add_row(OP_END, '0, 16'd6, '0);
endtask

initial begin
    reset       = 1'b1;
    bus_cs_n    = 1'b1;
    bus_rd_nwr  = 1'b0;
    bus_reg_num = 4'd0;
    bus_bytesel = 1'b0;
    bus_wdata   = 8'h00;
    build_table();
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    foreach (stim_q[i]) begin
        apply_row(stim_q[i]);
    end
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
        $display("sim passed");
    end else begin
        $display("sim failed");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== compile.f ====
common/vram_blit_pkg.sv
regs/reg_interface.sv
blit/blit_fsm.sv
blit/blit_counter.sv
vram/vram_arb.sv
src/vram_blit_top.sv
test/vram_blit_properties.sv
test/vram_blit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run the testbench and judge the log
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module vram_blit_tb -f compile.f
if ! ./obj_dir/Vvram_blit_tb > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi
cat sim.log
if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0
